/* rtl/gbcore_config.svh */
`ifndef GBCORE_CONFIG_SVH
`define GBCORE_CONFIG_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define GB_DATA_W       8
`define GB_ADDR_W       16
`define GB_UPC_W        6
`define GB_UCODE_DEPTH  48

// Register state after reset
`define GB_RESET_PC     16'h0000
`define GB_RESET_A      8'h11

// ----------------------------------------
// Interrupts
// ----------------------------------------
`define GB_INT_COUNT    4

`define GB_VEC_VBLANK   16'h0040  // Request line 0, highest priority
`define GB_VEC_LCD      16'h0048
`define GB_VEC_TIMER    16'h0050
`define GB_VEC_JOYPAD   16'h0060  // Request line 3

// Fixed flows that the sequencer selects on its own
`define GB_FLOW_FETCH   6'd0
`define GB_FLOW_INT     6'd1

`endif

/* rtl/gbcore_pkg.sv */
package gbcore_pkg;

  // ----------------------------------------
  // Micro-commands
  // ----------------------------------------
  typedef enum logic [3:0]
  {
    nop,
    setAddr,   // Latch address source, request a read
    loadMem,   // Bus byte into a register
    storeMem,  // Register onto the bus with write enable
    aluOp,     // Register to register, decoded from the opcode
    setIe,
    clrIe,
    jumpInt    // Vector into PC, drop the request latch
  } uopCmd;

  // Register index follows the opcode field coding, (HL) slot is the pair
  typedef enum logic [3:0]
  {
    regB    = 4'd0,
    regC    = 4'd1,
    regD    = 4'd2,
    regE    = 4'd3,
    regH    = 4'd4,
    regL    = 4'd5,
    regHL   = 4'd6,
    regA    = 4'd7,
    regPC   = 4'd8,
    regNull = 4'd9
  } regIndex;

  // ----------------------------------------
  // One microcode word, 14 bits
  // ----------------------------------------
  typedef struct packed
  {
    logic       incPc;
    logic       endFlow;       // Last word of the flow
    uopCmd      cmd;
    regIndex    operand;
    logic       useOpcodeReg;  // Registers from opcode bits 5:3 and 2:0
    logic [2:0] spare;
  } microOp;

endpackage

/* rtl/gbcore_ucode_rom.sv */
`include "gbcore_config.svh"

module gbcore_ucode_rom
(
  input  logic [`GB_UPC_W-1:0]  upc,
  input  logic [`GB_DATA_W-1:0] opcode,
  output gbcore_pkg::microOp    uop,
  output logic [`GB_UPC_W-1:0]  flowStart
);
  localparam logic [`GB_UPC_W-1:0] FlowFetch   = `GB_FLOW_FETCH;
  localparam logic [`GB_UPC_W-1:0] FlowInt     = `GB_FLOW_INT;
  localparam logic [`GB_UPC_W-1:0] FlowNop     = 6'd2;
  localparam logic [`GB_UPC_W-1:0] FlowEi      = 6'd3;
  localparam logic [`GB_UPC_W-1:0] FlowDi      = 6'd4;
  localparam logic [`GB_UPC_W-1:0] FlowLdRr    = 6'd5;
  localparam logic [`GB_UPC_W-1:0] FlowAlu     = 6'd6;
  localparam logic [`GB_UPC_W-1:0] FlowLdStore = 6'd7;
  localparam logic [`GB_UPC_W-1:0] FlowLdImm   = 6'd8;   // Seven pairs, B C D E H L A
  localparam logic [`GB_UPC_W-1:0] FlowLdLoad  = 6'd22;  // Seven pairs, same order

  function automatic gbcore_pkg::microOp mkOp
  (
    input logic                inc,
    input logic                last,
    input gbcore_pkg::uopCmd   cmd,
    input gbcore_pkg::regIndex opnd,
    input logic                useOp
  );
    mkOp = '{incPc: inc, endFlow: last, cmd: cmd, operand: opnd,
             useOpcodeReg: useOp, spare: 3'b000};
  endfunction

  // Pair offset of a destination field, A takes the slot of (HL)
  function automatic logic [`GB_UPC_W-1:0] slot(input logic [2:0] field);
    logic [2:0] idx;
    idx  = (field == 3'd7) ? 3'd6 : field;
    slot = {{(`GB_UPC_W-4){1'b0}}, idx, 1'b0};
  endfunction

  // ----------------------------------------
  // Microcode
  // ----------------------------------------
  function automatic gbcore_pkg::microOp romWord(input logic [`GB_UPC_W-1:0] addr);
    case (addr)
      FlowFetch:   romWord = mkOp(1'b1, 1'b1, gbcore_pkg::setAddr, gbcore_pkg::regPC, 1'b0);
      FlowInt:     romWord = mkOp(1'b0, 1'b1, gbcore_pkg::jumpInt, gbcore_pkg::regPC, 1'b0);
      FlowEi:      romWord = mkOp(1'b0, 1'b1, gbcore_pkg::setIe, gbcore_pkg::regNull, 1'b0);
      FlowDi:      romWord = mkOp(1'b0, 1'b1, gbcore_pkg::clrIe, gbcore_pkg::regNull, 1'b0);
      FlowLdRr:    romWord = mkOp(1'b0, 1'b1, gbcore_pkg::aluOp, gbcore_pkg::regNull, 1'b1);
      FlowAlu:     romWord = mkOp(1'b0, 1'b1, gbcore_pkg::aluOp, gbcore_pkg::regA, 1'b1);
      FlowLdStore: romWord = mkOp(1'b0, 1'b1, gbcore_pkg::storeMem, gbcore_pkg::regHL, 1'b1);
      6'd8, 6'd10, 6'd12, 6'd14, 6'd16, 6'd18, 6'd20:
        romWord = mkOp(1'b1, 1'b0, gbcore_pkg::setAddr, gbcore_pkg::regPC, 1'b0);  // Immediate
      6'd22, 6'd24, 6'd26, 6'd28, 6'd30, 6'd32, 6'd34:
        romWord = mkOp(1'b0, 1'b0, gbcore_pkg::setAddr, gbcore_pkg::regHL, 1'b0);
      6'd9,  6'd23: romWord = mkOp(1'b0, 1'b1, gbcore_pkg::loadMem, gbcore_pkg::regB, 1'b0);
      6'd11, 6'd25: romWord = mkOp(1'b0, 1'b1, gbcore_pkg::loadMem, gbcore_pkg::regC, 1'b0);
      6'd13, 6'd27: romWord = mkOp(1'b0, 1'b1, gbcore_pkg::loadMem, gbcore_pkg::regD, 1'b0);
      6'd15, 6'd29: romWord = mkOp(1'b0, 1'b1, gbcore_pkg::loadMem, gbcore_pkg::regE, 1'b0);
      6'd17, 6'd31: romWord = mkOp(1'b0, 1'b1, gbcore_pkg::loadMem, gbcore_pkg::regH, 1'b0);
      6'd19, 6'd33: romWord = mkOp(1'b0, 1'b1, gbcore_pkg::loadMem, gbcore_pkg::regL, 1'b0);
      6'd21, 6'd35: romWord = mkOp(1'b0, 1'b1, gbcore_pkg::loadMem, gbcore_pkg::regA, 1'b0);
      default:     romWord = mkOp(1'b0, 1'b1, gbcore_pkg::nop, gbcore_pkg::regNull, 1'b0);
    endcase
  endfunction

  assign uop = romWord(upc);

  // Opcode to flow lookup, casez takes the first match
  always_comb
  begin
    flowStart = FlowNop;
    casez (opcode)
      8'b00???110: if (opcode[5:3] != 3'b110) flowStart = FlowLdImm + slot(opcode[5:3]);
      8'b01110110: flowStart = FlowNop;  // HALT
      8'b01110???: flowStart = FlowLdStore;
      8'b01???110: flowStart = FlowLdLoad + slot(opcode[5:3]);
      8'b01??????: flowStart = FlowLdRr;
      8'b1010????,
      8'b10110???: if (opcode[2:0] != 3'b110) flowStart = FlowAlu;
      8'hfb:       flowStart = FlowEi;
      8'hf3:       flowStart = FlowDi;
      default:     flowStart = FlowNop;
    endcase
  end

endmodule

/* rtl/gbcore_sequencer.sv */
`include "gbcore_config.svh"

module gbcore_sequencer
(
  input  logic                 iClock,
  input  logic                 rst,
  input  gbcore_pkg::microOp   uop,
  input  logic [`GB_UPC_W-1:0] flowStart,
  input  logic                 intPending,
  output logic [`GB_UPC_W-1:0] upc,
  output logic                 flowEnable
);
  typedef enum logic [1:0]
  {
    stateAfterReset,
    stateStartFlow,
    stateRunFlow,
    stateEndFlow
  } runState;

  runState state;
  runState nextState;
  logic    opcodeReady;  // Fetch done, opcode sits on the bus

  // ----------------------------------------
  // Run state machine
  // ----------------------------------------
  always_comb
  begin
    case (state)
      stateAfterReset: nextState = stateStartFlow;
      stateStartFlow:  nextState = stateRunFlow;
      stateRunFlow:    nextState = uop.endFlow ? stateEndFlow : stateRunFlow;
      stateEndFlow:    nextState = stateStartFlow;
      default:         nextState = stateAfterReset;
    endcase
  end

  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      state       <= stateAfterReset;
      upc         <= '0;
      opcodeReady <= 1'b0;
    end
    else
    begin
      state <= nextState;
      if (state == stateStartFlow)
      begin
        // Interrupts only replace a fetch, never a decoded opcode
        if (opcodeReady)
        begin
          upc         <= flowStart;
          opcodeReady <= 1'b0;
        end
        else if (intPending)
          upc <= `GB_FLOW_INT;
        else
        begin
          upc         <= `GB_FLOW_FETCH;
          opcodeReady <= 1'b1;
        end
      end
      else if (state == stateRunFlow)
        upc <= upc + 1'b1;
    end
  end

  assign flowEnable = (state == stateRunFlow);

endmodule

/* rtl/gbcore_int_ctrl.sv */
`include "gbcore_config.svh"

module gbcore_int_ctrl
(
  input  logic                     iClock,
  input  logic                     rst,
  input  logic [`GB_INT_COUNT-1:0] iInterruptRequests,
  input  logic                     setIe,
  input  logic                     clrIe,
  input  logic                     takeInt,
  output logic                     intPending,
  output logic [`GB_ADDR_W-1:0]    vector
);
  localparam logic [`GB_ADDR_W-1:0] VecTable [`GB_INT_COUNT] =
    '{`GB_VEC_VBLANK, `GB_VEC_LCD, `GB_VEC_TIMER, `GB_VEC_JOYPAD};

  logic [`GB_INT_COUNT-1:0] requestLatch;
  logic [`GB_INT_COUNT-1:0] maskedRequests;
  logic                     intEnable;

  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      requestLatch <= '0;
      intEnable    <= 1'b0;
    end
    else
    begin
      requestLatch <= takeInt ? '0 : (requestLatch | iInterruptRequests);
      if (takeInt || clrIe)
        intEnable <= 1'b0;  // Acceptance disables further interrupts
      else if (setIe)
        intEnable <= 1'b1;
    end
  end

  assign maskedRequests = requestLatch & {`GB_INT_COUNT{intEnable}};
  assign intPending     = |maskedRequests;

  // Lowest line wins, so scan downwards
  always_comb
  begin
    vector = '0;
    for (int i = `GB_INT_COUNT - 1; i >= 0; i--)
      if (maskedRequests[i])
        vector = VecTable[i];
  end

endmodule

/* rtl/gbcore_regfile.sv */
`include "gbcore_config.svh"

module gbcore_regfile
(
  input  logic                  iClock,
  input  logic                  rst,
  input  logic                  flowEnable,
  input  logic                  regWe,
  input  gbcore_pkg::regIndex   writeReg,
  input  logic [`GB_DATA_W-1:0] writeData,
  input  gbcore_pkg::regIndex   readReg,
  input  logic                  pcInc,
  input  logic                  pcLoad,
  input  logic [`GB_ADDR_W-1:0] pcValue,
  input  logic                  addrLatch,
  input  gbcore_pkg::regIndex   addrSrc,
  output logic [`GB_DATA_W-1:0] readData,
  output logic [`GB_DATA_W-1:0] regA,
  output logic [`GB_ADDR_W-1:0] pc,
  output logic [`GB_ADDR_W-1:0] busAddr
);
  logic [`GB_DATA_W-1:0] rB;
  logic [`GB_DATA_W-1:0] rC;
  logic [`GB_DATA_W-1:0] rD;
  logic [`GB_DATA_W-1:0] rE;
  logic [`GB_DATA_W-1:0] rH;
  logic [`GB_DATA_W-1:0] rL;
  gbcore_pkg::regIndex   addrSel;
  gbcore_pkg::regIndex   addrNow;

  // ----------------------------------------
  // Byte registers
  // ----------------------------------------
  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      rB   <= '0;
      rC   <= '0;
      rD   <= '0;
      rE   <= '0;
      rH   <= '0;
      rL   <= '0;
      regA <= `GB_RESET_A;
    end
    else if (regWe && flowEnable)
    begin
      case (writeReg)
        gbcore_pkg::regB: rB <= writeData;
        gbcore_pkg::regC: rC <= writeData;
        gbcore_pkg::regD: rD <= writeData;
        gbcore_pkg::regE: rE <= writeData;
        gbcore_pkg::regH: rH <= writeData;
        gbcore_pkg::regL: rL <= writeData;
        gbcore_pkg::regA: regA <= writeData;
        default: ;
      endcase
    end
  end

  // PC and bus address source
  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      pc      <= `GB_RESET_PC;
      addrSel <= gbcore_pkg::regPC;
    end
    else if (flowEnable)
    begin
      if (pcLoad)
        pc <= pcValue;
      else if (pcInc)
        pc <= pc + 1'b1;
      if (addrLatch)
        addrSel <= addrSrc;
    end
  end

  // New source drives the bus in the cycle it is latched
  assign addrNow = addrLatch ? addrSrc : addrSel;
  assign busAddr = (addrNow == gbcore_pkg::regHL) ? {rH, rL} : pc;

  always_comb
  begin
    case (readReg)
      gbcore_pkg::regB: readData = rB;
      gbcore_pkg::regC: readData = rC;
      gbcore_pkg::regD: readData = rD;
      gbcore_pkg::regE: readData = rE;
      gbcore_pkg::regH: readData = rH;
      gbcore_pkg::regL: readData = rL;
      gbcore_pkg::regA: readData = regA;
      default:          readData = '0;
    endcase
  end

endmodule

/* rtl/gbcore_exec.sv */
`include "gbcore_config.svh"

module gbcore_exec
(
  input  gbcore_pkg::microOp    uop,
  input  logic                  flowEnable,
  input  logic [`GB_DATA_W-1:0] opcode,     // Bus byte, the opcode until a flow reads
  input  logic [`GB_DATA_W-1:0] readData,
  input  logic [`GB_DATA_W-1:0] regA,
  input  logic [`GB_ADDR_W-1:0] vector,
  output logic                  regWe,
  output gbcore_pkg::regIndex   writeReg,
  output logic [`GB_DATA_W-1:0] writeData,
  output gbcore_pkg::regIndex   readReg,
  output logic                  pcInc,
  output logic                  pcLoad,
  output logic [`GB_ADDR_W-1:0] pcValue,
  output logic                  addrLatch,
  output gbcore_pkg::regIndex   addrSrc,
  output logic                  mcuReadRequest,
  output logic                  mcuWe,
  output logic [`GB_DATA_W-1:0] mcuData,
  output logic                  setIe,
  output logic                  clrIe,
  output logic                  takeInt
);
  gbcore_pkg::regIndex   dstReg;
  gbcore_pkg::regIndex   srcReg;
  logic [`GB_DATA_W-1:0] aluResult;

  assign dstReg = uop.useOpcodeReg ? gbcore_pkg::regIndex'({1'b0, opcode[5:3]}) : uop.operand;
  assign srcReg = uop.useOpcodeReg ? gbcore_pkg::regIndex'({1'b0, opcode[2:0]}) : uop.operand;

  assign pcValue = vector;
  assign mcuData = readData;

  // ----------------------------------------
  // Logic unit, loads pass the source
  // ----------------------------------------
  always_comb
  begin
    if (opcode[7:6] == 2'b01)
      aluResult = readData;  // LD r,r'
    else
    begin
      case (opcode[4:3])
        2'b00:   aluResult = regA & readData;
        2'b01:   aluResult = regA ^ readData;
        2'b10:   aluResult = regA | readData;
        default: aluResult = readData;
      endcase
    end
  end

  // Command decode
  always_comb
  begin
    regWe          = 1'b0;
    writeReg       = gbcore_pkg::regNull;
    writeData      = '0;
    readReg        = gbcore_pkg::regNull;
    pcInc          = 1'b0;
    pcLoad         = 1'b0;
    addrLatch      = 1'b0;
    addrSrc        = gbcore_pkg::regPC;
    mcuReadRequest = 1'b0;
    mcuWe          = 1'b0;
    setIe          = 1'b0;
    clrIe          = 1'b0;
    takeInt        = 1'b0;
    if (flowEnable)
    begin
      pcInc = uop.incPc;
      case (uop.cmd)
        gbcore_pkg::setAddr:
        begin
          addrLatch      = 1'b1;
          addrSrc        = uop.operand;
          mcuReadRequest = 1'b1;
        end
        gbcore_pkg::loadMem:
        begin
          regWe     = 1'b1;
          writeReg  = dstReg;
          writeData = opcode;
        end
        gbcore_pkg::storeMem:
        begin
          addrLatch = 1'b1;
          addrSrc   = uop.operand;  // Address from the word, data from the opcode
          readReg   = srcReg;
          mcuWe     = 1'b1;
        end
        gbcore_pkg::aluOp:
        begin
          readReg   = srcReg;
          regWe     = 1'b1;
          writeReg  = (opcode[7:6] == 2'b01) ? dstReg : gbcore_pkg::regA;
          writeData = aluResult;
        end
        gbcore_pkg::setIe:   setIe = 1'b1;
        gbcore_pkg::clrIe:   clrIe = 1'b1;
        gbcore_pkg::jumpInt:
        begin
          pcLoad  = 1'b1;
          takeInt = 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

/* rtl/gbcore_top.sv */
`include "gbcore_config.svh"

module gbcore_top
(
  input  logic                     iClock,
  input  logic                     rst,
  input  logic [`GB_DATA_W-1:0]    iMcuData,
  output logic [`GB_DATA_W-1:0]    oMcuData,
  output logic [`GB_ADDR_W-1:0]    oMcuAddr,
  output logic                     oMcuReadRequest,
  output logic                     oMcuWe,
  input  logic [`GB_INT_COUNT-1:0] iInterruptRequests
);
  logic [`GB_UPC_W-1:0]  upc;
  logic [`GB_UPC_W-1:0]  flowStart;
  gbcore_pkg::microOp    uop;
  logic                  flowEnable;
  logic                  intPending;
  logic [`GB_ADDR_W-1:0] vector;
  logic                  regWe;
  gbcore_pkg::regIndex   writeReg;
  logic [`GB_DATA_W-1:0] writeData;
  gbcore_pkg::regIndex   readReg;
  logic [`GB_DATA_W-1:0] readData;
  logic [`GB_DATA_W-1:0] regA;
  logic                  pcInc;
  logic                  pcLoad;
  logic [`GB_ADDR_W-1:0] pcValue;
  logic                  addrLatch;
  gbcore_pkg::regIndex   addrSrc;
  logic                  setIe;
  logic                  clrIe;
  logic                  takeInt;

  // ----------------------------------------
  // Control
  // ----------------------------------------
  gbcore_sequencer uSequencer
  (
    .iClock, .rst, .uop, .flowStart, .intPending, .upc, .flowEnable
  );

  gbcore_ucode_rom uRom
  (
    .upc, .opcode(iMcuData), .uop, .flowStart
  );

  gbcore_int_ctrl uIntCtrl
  (
    .iClock, .rst, .iInterruptRequests, .setIe, .clrIe, .takeInt, .intPending, .vector
  );

  // Datapath
  gbcore_regfile uRegfile
  (
    .iClock, .rst, .flowEnable, .regWe, .writeReg, .writeData, .readReg,
    .pcInc, .pcLoad, .pcValue, .addrLatch, .addrSrc,
    .readData, .regA, .pc(), .busAddr(oMcuAddr)
  );

  gbcore_exec uExec
  (
    .uop, .flowEnable, .opcode(iMcuData), .readData, .regA, .vector,
    .regWe, .writeReg, .writeData, .readReg, .pcInc, .pcLoad, .pcValue,
    .addrLatch, .addrSrc, .mcuReadRequest(oMcuReadRequest), .mcuWe(oMcuWe),
    .mcuData(oMcuData), .setIe, .clrIe, .takeInt
  );

endmodule

/* testbench/gbcore_assert.sv */
`include "gbcore_config.svh"

module gbcore_assert
(
  input logic                  iClock,
  input logic                  rst,
  input logic                  readRequest,
  input logic                  we,
  input logic [`GB_ADDR_W-1:0] addr,
  input logic                  takeInt
);
  timeunit 1ns;
  timeprecision 100ps;

  logic awaitVector;  // From acceptance up to the next read

  always @(posedge iClock)
  begin
    if (rst)
      awaitVector <= 1'b0;
    else if (takeInt)
      awaitVector <= 1'b1;
    else if (readRequest)
      awaitVector <= 1'b0;
  end

  // ----------------------------------------
  noReadWithWrite: assert property (@(posedge iClock) !(readRequest && we))
    else $error("read request and write enable high in the same cycle");

  quietInReset: assert property (@(posedge iClock) $past(rst) |-> (!readRequest && !we))
    else $error("bus strobe active while reset is held");

  vectorAfterInt: assert property (@(posedge iClock) disable iff (rst)
    (awaitVector && readRequest) |->
      (addr inside {`GB_VEC_VBLANK, `GB_VEC_LCD, `GB_VEC_TIMER, `GB_VEC_JOYPAD}))
    else $error("first read after interrupt acceptance is not at a vector");

endmodule

bind gbcore_top gbcore_assert uAssert
(
  .iClock, .rst, .readRequest(oMcuReadRequest), .we(oMcuWe), .addr(oMcuAddr), .takeInt
);

/* testbench/gbcore_tb.sv */
`include "gbcore_config.svh"

module gbcore_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClockPeriod = 40;
  localparam int ResetCycles = 4;
  localparam int MemSize     = 1 << `GB_ADDR_W;

  // Program lengths in bytes
  localparam int FetchLen  = 8;
  localparam int StoreLen  = 22;
  localparam int CopyLen   = 18;
  localparam int AluLen    = 20;
  localparam int MaskLen   = 16;
  localparam int IntLen    = 24;
  localparam int TestCount = 6;
  localparam int WatchdogCycles =
    (FetchLen + StoreLen + CopyLen + AluLen + MaskLen + IntLen) * 8 +
    TestCount * ResetCycles + 200;

  logic                     iClock;
  logic                     rst;
  logic [`GB_DATA_W-1:0]    iMcuData = '0;
  logic [`GB_DATA_W-1:0]    oMcuData;
  logic [`GB_ADDR_W-1:0]    oMcuAddr;
  logic                     oMcuReadRequest;
  logic                     oMcuWe;
  logic [`GB_INT_COUNT-1:0] iInterruptRequests;

  logic [`GB_DATA_W-1:0] mem [MemSize];
  logic [`GB_ADDR_W-1:0] imageAddr [$];  // Program image, placed at the next boot
  logic [`GB_DATA_W-1:0] imageData [$];
  logic [`GB_ADDR_W-1:0] emitAddr;
  logic [31:0]           lfsrState;
  int                    errorCount;
  int                    checkCount;

  gbcore_top i_dut
  (
    .iClock, .rst, .iMcuData, .oMcuData, .oMcuAddr, .oMcuReadRequest, .oMcuWe,
    .iInterruptRequests
  );

  initial
  begin
    iClock = 1'b0;
    forever #(ClockPeriod / 2) iClock = ~iClock;
  end

  // Synchronous memory, byte stays on the bus until the next read
  always @(posedge iClock)
  begin
    if (oMcuReadRequest)
      iMcuData <= mem[oMcuAddr];
    if (oMcuWe)
      mem[oMcuAddr] <= oMcuData;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    logic [31:0] nextState;
    nextState = state >> 1;
    if (state[0])
      nextState = nextState ^ 32'h80200003;
    return nextState;
  endfunction

  task automatic randomByte(output logic [`GB_DATA_W-1:0] value);
    for (int i = 0; i < `GB_DATA_W; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      value[i]  = lfsrState[0];
    end
  endtask

  function automatic logic [`GB_DATA_W-1:0] fillByte(input logic [`GB_ADDR_W-1:0] addr);
    return addr[15:8] ^ {addr[6:0], addr[7]} ^ 8'h3c;
  endfunction

  task automatic setOrigin(input logic [`GB_ADDR_W-1:0] addr);
    emitAddr = addr;
  endtask

  task automatic emitByte(input logic [`GB_DATA_W-1:0] value);
    imageAddr.push_back(emitAddr);
    imageData.push_back(value);
    emitAddr = emitAddr + 16'd1;
  endtask

  task automatic emitPair(input logic [`GB_DATA_W-1:0] op, input logic [`GB_DATA_W-1:0] imm);
    emitByte(op);
    emitByte(imm);
  endtask

  // Memory is loaded once the core is held quiet in reset
  task automatic bootProgram();
    @(posedge iClock);
    rst                <= 1'b1;
    iInterruptRequests <= '0;
    repeat (2) @(posedge iClock);
    for (int a = 0; a < MemSize; a++)
      mem[a] <= fillByte(16'(a));
    foreach (imageAddr[i])
      mem[imageAddr[i]] <= imageData[i];
    imageAddr.delete();
    imageData.delete();
    repeat (ResetCycles - 2) @(posedge iClock);
    rst <= 1'b0;
  endtask

  task automatic nextRead(output logic [`GB_ADDR_W-1:0] addr);
    do
      @(negedge iClock);
    while (!oMcuReadRequest);
    addr = oMcuAddr;
  endtask

  task automatic nextWrite(output logic [`GB_ADDR_W-1:0] addr,
                           output logic [`GB_DATA_W-1:0] data);
    do
      @(negedge iClock);
    while (!oMcuWe);
    addr = oMcuAddr;
    data = oMcuData;
  endtask

  task automatic pulseRequests(input logic [`GB_INT_COUNT-1:0] lines);
    @(posedge iClock);
    iInterruptRequests <= lines;
    @(posedge iClock);
    iInterruptRequests <= '0;
  endtask

  task automatic checkAddr(input string name, input logic [`GB_ADDR_W-1:0] actual,
                           input logic [`GB_ADDR_W-1:0] expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic checkData(input string name, input logic [`GB_DATA_W-1:0] actual,
                           input logic [`GB_DATA_W-1:0] expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic testFetchOrder();
    logic [`GB_ADDR_W-1:0] addr;
    logic [`GB_DATA_W-1:0] imm;
    setOrigin(`GB_RESET_PC);
    emitByte(8'h00);
    emitByte(8'h00);
    randomByte(imm);
    emitPair(8'h06, imm);  // LD B,n
    emitByte(8'h00);
    randomByte(imm);
    emitPair(8'h0e, imm);
    emitByte(8'h00);
    bootProgram();
    for (int i = 0; i < FetchLen; i++)
    begin
      nextRead(addr);
      checkAddr("oMcuAddr", addr, 16'(`GB_RESET_PC + i));
    end
  endtask

  task automatic testLoadStore();
    logic [`GB_DATA_W-1:0] value [7];  // B C D E H L A
    logic [`GB_ADDR_W-1:0] hl;
    logic [`GB_ADDR_W-1:0] addr;
    logic [`GB_DATA_W-1:0] data;
    for (int r = 0; r < 7; r++)
      randomByte(value[r]);
    value[4][7] = 1'b1;  // Keep (HL) above the program
    hl = {value[4], value[5]};
    setOrigin(`GB_RESET_PC);
    for (int r = 0; r < 6; r++)
      emitPair({2'b00, 3'(r), 3'b110}, value[r]);
    emitByte(8'h77);  // A not loaded yet
    for (int r = 0; r < 6; r++)
      emitByte({5'b01110, 3'(r)});
    emitPair(8'h3e, value[6]);
    emitByte(8'h77);
    bootProgram();
    nextWrite(addr, data);
    checkAddr("oMcuAddr", addr, hl);
    checkData("oMcuData", data, `GB_RESET_A);
    for (int r = 0; r < 7; r++)
    begin
      nextWrite(addr, data);
      checkAddr("oMcuAddr", addr, hl);
      checkData("oMcuData", data, value[r]);
    end
  endtask

  task automatic testCopyAndLoad();
    logic [`GB_DATA_W-1:0] b;
    logic [`GB_DATA_W-1:0] h;
    logic [`GB_DATA_W-1:0] l;
    logic [`GB_ADDR_W-1:0] farAddr;
    logic [`GB_ADDR_W-1:0] addr;
    logic [`GB_DATA_W-1:0] data;
    randomByte(b);
    randomByte(h);
    randomByte(l);
    h[7]    = 1'b1;
    farAddr = {h, ~l};
    setOrigin(`GB_RESET_PC);
    emitPair(8'h06, b);
    emitByte(8'h48);  // LD C,B
    emitByte(8'h51);  // LD D,C
    emitByte(8'h5a);  // LD E,D
    emitByte(8'h7b);  // LD A,E
    emitPair(8'h26, h);
    emitPair(8'h2e, l);
    emitByte(8'h71);
    emitByte(8'h72);
    emitByte(8'h73);
    emitByte(8'h77);
    emitPair(8'h2e, ~l);
    emitByte(8'h5e);  // LD E,(HL)
    emitByte(8'h73);
    bootProgram();
    repeat (4)
    begin
      nextWrite(addr, data);
      checkAddr("oMcuAddr", addr, {h, l});
      checkData("oMcuData", data, b);
    end
    nextWrite(addr, data);
    checkAddr("oMcuAddr", addr, farAddr);
    checkData("oMcuData", data, fillByte(farAddr));
  endtask

  task automatic testLogicOps();
    logic [`GB_DATA_W-1:0] a;
    logic [`GB_DATA_W-1:0] b;
    logic [`GB_DATA_W-1:0] c;
    logic [`GB_DATA_W-1:0] d;
    logic [`GB_DATA_W-1:0] h;
    logic [`GB_DATA_W-1:0] l;
    logic [`GB_DATA_W-1:0] expected [4];
    logic [`GB_ADDR_W-1:0] addr;
    logic [`GB_DATA_W-1:0] data;
    randomByte(a);
    randomByte(b);
    randomByte(c);
    randomByte(d);
    randomByte(h);
    randomByte(l);
    h[7] = 1'b1;
    expected[0] = a & b;
    expected[1] = expected[0] ^ c;
    expected[2] = expected[1] | d;
    expected[3] = '0;  // XOR A with itself
    setOrigin(`GB_RESET_PC);
    emitPair(8'h3e, a);
    emitPair(8'h06, b);
    emitByte(8'ha0);  // AND B
    emitPair(8'h26, h);
    emitPair(8'h2e, l);
    emitByte(8'h77);
    emitPair(8'h0e, c);
    emitByte(8'ha9);  // XOR C
    emitByte(8'h77);
    emitPair(8'h16, d);
    emitByte(8'hb2);  // OR D
    emitByte(8'h77);
    emitByte(8'haf);
    emitByte(8'h77);
    bootProgram();
    for (int i = 0; i < 4; i++)
    begin
      nextWrite(addr, data);
      checkAddr("oMcuAddr", addr, {h, l});
      checkData("oMcuData", data, expected[i]);
    end
  endtask

  task automatic testMaskedRequest();
    logic [`GB_ADDR_W-1:0] addr;
    setOrigin(`GB_RESET_PC);
    emitByte(8'hfb);  // EI, so only DI can mask the request
    emitByte(8'h00);
    emitByte(8'hf3);  // DI
    repeat (MaskLen - 3) emitByte(8'h00);
    bootProgram();
    for (int i = 0; i < 4; i++)
    begin
      nextRead(addr);
      checkAddr("oMcuAddr", addr, 16'(`GB_RESET_PC + i));
    end
    pulseRequests(4'b0100);
    for (int i = 4; i < 9; i++)
    begin
      nextRead(addr);
      checkAddr("oMcuAddr", addr, 16'(`GB_RESET_PC + i));
    end
  endtask

  task automatic testInterrupts();
    logic [`GB_ADDR_W-1:0] addr;
    setOrigin(`GB_RESET_PC);
    emitByte(8'hfb);  // EI
    repeat (15) emitByte(8'h00);
    setOrigin(`GB_VEC_LCD);
    repeat (3) emitByte(8'h00);
    emitByte(8'hfb);
    repeat (4) emitByte(8'h00);
    bootProgram();
    for (int i = 0; i < 3; i++)
    begin
      nextRead(addr);
      checkAddr("oMcuAddr", addr, 16'(`GB_RESET_PC + i));
    end
    pulseRequests(4'b1010);  // Lowest raised line is the LCD one
    nextRead(addr);
    checkAddr("oMcuAddr", addr, `GB_VEC_LCD);
    pulseRequests(4'b0001);
    for (int i = 1; i < 4; i++)
    begin
      nextRead(addr);
      checkAddr("oMcuAddr", addr, 16'(`GB_VEC_LCD + i));
    end
    nextRead(addr);  // Latched request taken after the second EI
    checkAddr("oMcuAddr", addr, `GB_VEC_VBLANK);
  endtask

  // ----------------------------------------
  // Run control
  // ----------------------------------------
  initial
  begin
    rst                <= 1'b1;
    iInterruptRequests <= '0;
    lfsrState  = 32'hb75bbf3f;
    errorCount = 0;
    checkCount = 0;
    testFetchOrder();
    testLoadStore();
    testCopyAndLoad();
    testLogicOps();
    testMaskedRequest();
    testInterrupts();
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    repeat (WatchdogCycles) @(posedge iClock);
    $display("watchdog expired after %0d cycles, expected bus events never came",
             WatchdogCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* build.f */
+incdir+rtl
rtl/gbcore_pkg.sv
rtl/gbcore_ucode_rom.sv
rtl/gbcore_sequencer.sv
rtl/gbcore_int_ctrl.sv
rtl/gbcore_regfile.sv
rtl/gbcore_exec.sv
rtl/gbcore_top.sv
testbench/gbcore_assert.sv
testbench/gbcore_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
  -f build.f --top-module gbcore_tb --Mdir "$OBJ" -o gbcore_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$OBJ/gbcore_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
